// File: sim/color_mapper_tb.sv
`default_nettype none

module color_mapper_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import color_pkg::*;

    localparam logic [31:0] seed_init = 32'hc182_db31;
    localparam int cycle_limit = 3 * h_total * v_total + 2000;

    wire clk;
    wire rst_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [3:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [n_ship-1:0] ship_hit;
    pix_idx_t [n_ship-1:0] ship_idx;
    logic [n_weapon-1:0] weapon_hit;
    pix_idx_t [n_weapon-1:0] weapon_idx;
    pix_idx_t bg_idx;
    coord_t draw_x;
    coord_t draw_y;
    logic [7:0] vga_r;
    logic [7:0] vga_g;
    logic [7:0] vga_b;
    logic hsync;
    logic vsync;

    logic [31:0] seed = seed_init;
    logic [1:0] cur_sel_0 = 2'd0;
    logic [1:0] cur_sel_1 = 2'd0;
    int cycle_count = 0;
    int pix_count = 0;

    tb_clock clock_gen (.clk(clk), .rst_n(rst_n));

    color_mapper_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .ship_hit(ship_hit), .ship_idx(ship_idx), .weapon_hit(weapon_hit),
        .weapon_idx(weapon_idx), .bg_idx(bg_idx),
        .draw_x(draw_x), .draw_y(draw_y),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .hsync(hsync), .vsync(vsync)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation stopped by the timeout counter");
        end
    end

    // Raster position model, one pixel per clock after reset
    always @(posedge clk) begin
        if (rst_n) begin
            pix_count++;
        end
    end

    // --------------------
    // Helpers
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic rgb_t ship_lookup(input logic [1:0] sel, input logic [3:0] idx);
        case (sel)
            2'd1:    return ship_palette_1[idx];
            2'd2:    return ship_palette_2[idx];
            default: return ship_palette_0[idx];
        endcase
    endfunction

    // Reference mixer: weapons by lowest slot, then ship 0, ship 1, background
    function automatic rgb_t expected_color(input logic [1:0] sh, input logic [7:0] si,
                                            input logic [3:0] wh, input logic [15:0] wi,
                                            input logic [3:0] bg);
        rgb_t c;
        rgb_t s0;
        rgb_t s1;
        rgb_t wc;
        logic found;
        c = bg_palette[bg];
        s0 = ship_lookup(cur_sel_0, si[3:0]);
        s1 = ship_lookup(cur_sel_1, si[7:4]);
        found = 1'b0;
        if (sh[1] && (s1 != ship_key)) c = s1;
        if (sh[0] && (s0 != ship_key)) c = s0;
        for (int w = 0; w < n_weapon; w++) begin
            wc = weapon_palette[wi[4*w +: 4]];
            if (!found && wh[w] && (wc != weapon_key)) begin
                c = wc;
                found = 1'b1;
            end
        end
        return c;
    endfunction

    // Called on a falling edge; checks the registered pixel one cycle later
    task automatic drive_and_check(input logic [1:0] sh, input logic [7:0] si,
                                   input logic [3:0] wh, input logic [15:0] wi,
                                   input logic [3:0] bg);
        rgb_t exp;
        logic exp_hs;
        logic exp_vs;
        int x;
        int y;
        x = pix_count % h_total;
        y = (pix_count / h_total) % v_total;
        check_value("draw_x", draw_x, x);
        check_value("draw_y", draw_y, y);
        ship_hit = sh;
        ship_idx = si;
        weapon_hit = wh;
        weapon_idx = wi;
        bg_idx = bg;
        if ((x >= h_visible) || (y >= v_visible)) exp = '0;
        else exp = expected_color(sh, si, wh, wi, bg);
        exp_hs = !((x >= h_visible + h_front) && (x < h_visible + h_front + h_sync));
        exp_vs = !((y >= v_visible + v_front) && (y < v_visible + v_front + v_sync));
        @(negedge clk);
        check_value("vga_r", vga_r, exp[23:16]);
        check_value("vga_g", vga_g, exp[15:8]);
        check_value("vga_b", vga_b, exp[7:0]);
        check_value("hsync", hsync, exp_hs);
        check_value("vsync", vsync, exp_vs);
    endtask

    task automatic move_to_visible();
        while ((draw_x >= h_visible - 20) || (draw_y >= v_visible)) begin
            drive_and_check('0, '0, '0, '0, '0);
        end
    endtask

    task automatic wait_vblank();
        while (!((draw_y == v_visible) && (draw_x == 0))) begin
            drive_and_check('0, '0, '0, '0, '0);
        end
    endtask

    // --------------------
    // APB driver, sampled inside the access cycle
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic exp_err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #10;
        check_value("pready", pready, 1'b1);
        check_value("pslverr", pslverr, exp_err);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, input logic [31:0] exp);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        #10;
        check_value("pready", pready, 1'b1);
        check_value("pslverr", pslverr, 1'b0);
        check_value("prdata", prdata, exp);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // --------------------
    // Tests
    task automatic test_reset();
        check_value("vga_r", vga_r, 8'h00);
        check_value("vga_g", vga_g, 8'h00);
        check_value("vga_b", vga_b, 8'h00);
        check_value("draw_x", draw_x, 0);
        check_value("draw_y", draw_y, 0);
        check_value("hsync", hsync, 1'b1);
        check_value("vsync", vsync, 1'b1);
        apb_read(addr_active, 32'h0);
    endtask

    task automatic test_background();
        logic [31:0] r;
        for (int i = 0; i < 2 * h_total + 100; i++) begin
            r = next_rand();
            drive_and_check('0, '0, '0, '0, r[19:16]);
        end
    endtask

    task automatic test_ships();
        move_to_visible();
        drive_and_check(2'b01, 8'h01, '0, '0, 4'h3);
        drive_and_check(2'b11, 8'h30, '0, '0, 4'h5);
        drive_and_check(2'b11, 8'h00, '0, '0, 4'h9);
        drive_and_check(2'b10, 8'h50, '0, '0, 4'h2);
    endtask

    task automatic test_weapons();
        move_to_visible();
        drive_and_check(2'b11, 8'h31, 4'b0110, 16'h0540, 4'h1);
        drive_and_check(2'b11, 8'h31, 4'b0111, 16'h0541, 4'h1);
        drive_and_check(2'b11, 8'h31, 4'b1011, 16'h1011, 4'h1);
        drive_and_check(2'b01, 8'h01, 4'b0001, 16'h0000, 4'h6);
    endtask

    task automatic test_commit();
        apb_write(addr_pending, 32'h6, 1'b0);
        apb_read(addr_status, 32'h1);
        apb_read(addr_active, 32'h0);
        apb_read(addr_pending, 32'h6);
        move_to_visible();
        drive_and_check(2'b11, 8'hc1, '0, '0, 4'h4);
        drive_and_check(2'b10, 8'h00, '0, '0, 4'h4);
        wait_vblank();
        repeat (3) drive_and_check('0, '0, '0, '0, '0);
        cur_sel_0 = 2'd2;
        cur_sel_1 = 2'd1;
        apb_read(addr_active, 32'h6);
        apb_read(addr_status, 32'h0);
        move_to_visible();
        drive_and_check(2'b11, 8'hc1, '0, '0, 4'h4);
        drive_and_check(2'b10, 8'h00, '0, '0, 4'h4);
        apb_write(addr_active, 32'h3, 1'b1);
        apb_read(addr_active, 32'h6);
    endtask

    initial begin : stimulus
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        ship_hit = '0;
        ship_idx = '0;
        weapon_hit = '0;
        weapon_idx = '0;
        bg_idx = '0;
        wait (rst_n === 1'b1);
        test_reset();
        test_background();
        test_ships();
        test_weapons();
        test_commit();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period = 20;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release on a falling edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: src/color_mapper_top.sv
`default_nettype none

module color_mapper_top (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire                                                psel,
    input  wire                                                penable,
    input  wire                                                pwrite,
    input  wire  [3:0]                                         paddr,
    input  wire  [31:0]                                        pwdata,
    output logic [31:0]                                        prdata,
    output logic                                               pready,
    output logic                                               pslverr,
    input  wire  [color_pkg::n_ship-1:0]                       ship_hit,
    input  wire  color_pkg::pix_idx_t [color_pkg::n_ship-1:0]  ship_idx,
    input  wire  [color_pkg::n_weapon-1:0]                     weapon_hit,
    input  wire  color_pkg::pix_idx_t [color_pkg::n_weapon-1:0] weapon_idx,
    input  wire  color_pkg::pix_idx_t                          bg_idx,
    output color_pkg::coord_t                                  draw_x,
    output color_pkg::coord_t                                  draw_y,
    output logic [7:0]                                         vga_r,
    output logic [7:0]                                         vga_g,
    output logic [7:0]                                         vga_b,
    output logic                                               hsync,
    output logic                                               vsync
);
    import color_pkg::*;

    wire                    blank;
    wire                    hsync_raw;
    wire                    vsync_raw;
    wire                    vblank_start;
    wire pal_sel_t          active_sel_0;
    wire pal_sel_t          active_sel_1;
    wire rgb_t [n_ship-1:0] ship_color;
    wire [n_ship-1:0]       ship_transparent;

    raster_counter u_raster (
        .clk          (clk),
        .rst_n        (rst_n),
        .draw_x       (draw_x),
        .draw_y       (draw_y),
        .blank        (blank),
        .hsync_raw    (hsync_raw),
        .vsync_raw    (vsync_raw),
        .vblank_start (vblank_start)
    );

    frame_config u_config (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .vblank_start (vblank_start),
        .active_sel_0 (active_sel_0),
        .active_sel_1 (active_sel_1)
    );

    // One palette lookup per ship
    ship_palette u_ship_pal_0 (
        .sel         (active_sel_0),
        .idx         (ship_idx[0]),
        .color       (ship_color[0]),
        .transparent (ship_transparent[0])
    );

    ship_palette u_ship_pal_1 (
        .sel         (active_sel_1),
        .idx         (ship_idx[1]),
        .color       (ship_color[1]),
        .transparent (ship_transparent[1])
    );

    layer_mixer u_mixer (
        .clk              (clk),
        .rst_n            (rst_n),
        .blank            (blank),
        .hsync_raw        (hsync_raw),
        .vsync_raw        (vsync_raw),
        .bg_idx           (bg_idx),
        .ship_hit         (ship_hit),
        .ship_color       (ship_color),
        .ship_transparent (ship_transparent),
        .weapon_hit       (weapon_hit),
        .weapon_idx       (weapon_idx),
        .vga_r            (vga_r),
        .vga_g            (vga_g),
        .vga_b            (vga_b),
        .hsync            (hsync),
        .vsync            (vsync)
    );

endmodule

`default_nettype wire

// File: src/color_pkg.sv
`default_nettype none

package color_pkg;

    typedef logic [23:0] rgb_t;
    typedef logic [3:0]  pix_idx_t;
    typedef logic [1:0]  pal_sel_t;
    typedef logic [9:0]  coord_t;

    // --------------------
    // Raster timing, 640x480 inside 800x525
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_total   = 800;

    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_total   = 525;

    localparam int n_weapon = 4;
    localparam int n_ship   = 2;

    // --------------------
    // Palettes
    localparam rgb_t bg_palette [16] = '{
        24'h0f4792, 24'h3577cd, 24'h4fc3fc, 24'h4586d9, 24'h033477, 24'h4176bb,
        24'h4faafb, 24'h043578, 24'h4b93ed, 24'hfff78f, 24'h505050, 24'h535c74,
        24'hdfc5ae, 24'h9ea7af, 24'h000000, 24'hffffff};

    localparam rgb_t ship_palette_0 [16] = '{
        24'h808080, 24'hf3f1f3, 24'h201c18, 24'hfffbef, 24'h3b3b3b, 24'h54657b,
        24'haa3e49, 24'h767778, 24'hbe3647, 24'hfff78f, 24'h505050, 24'h535c74,
        24'hdfc5ae, 24'h9ea7af, 24'h000000, 24'hffffff};

    localparam rgb_t ship_palette_1 [16] = '{
        24'hf9f1e9, 24'hc25f4f, 24'h686554, 24'hd7c1b2, 24'h455273, 24'hffd1c0,
        24'hf19a3e, 24'h362e3e, 24'h8594a5, 24'hf4f0e8, 24'h505050, 24'h535c74,
        24'h808080, 24'h9ea7af, 24'h000000, 24'hffffff};

    localparam rgb_t ship_palette_2 [16] = '{
        24'h695871, 24'h808080, 24'hefe7e7, 24'h694a82, 24'h4d5ea2, 24'ha5a3a2,
        24'hfed9d2, 24'h9e7d64, 24'h474757, 24'h6f4d90, 24'h544058, 24'h322a4c,
        24'heee7e7, 24'h9ea7af, 24'h000000, 24'hffffff};

    localparam rgb_t weapon_palette [16] = '{
        24'h808080, 24'hffffff, 24'h3c3c3e, 24'h686a70, 24'he27a55, 24'hffd778,
        24'hba160d, 24'hffffe1, 24'hca2d27, 24'he9a16c, 24'h505050, 24'h535c74,
        24'hdfc5ae, 24'h9ea7af, 24'h000000, 24'hfb2901};

    // Transparency keys
    localparam rgb_t ship_key   = 24'h808080;
    localparam rgb_t weapon_key = 24'hffffff;

    // --------------------
    // Register map and config FSM states
    localparam logic [3:0] addr_pending = 4'h0;
    localparam logic [3:0] addr_active  = 4'h4;
    localparam logic [3:0] addr_status  = 4'h8;

    localparam logic [1:0] cfg_idle    = 2'd0;
    localparam logic [1:0] cfg_pending = 2'd1;
    localparam logic [1:0] cfg_commit  = 2'd2;

endpackage

`default_nettype wire

// File: src/frame_config.sv
`default_nettype none

module frame_config (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 psel,
    input  wire                 penable,
    input  wire                 pwrite,
    input  wire  [3:0]          paddr,
    input  wire  [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  wire                 vblank_start,
    output color_pkg::pal_sel_t active_sel_0,
    output color_pkg::pal_sel_t active_sel_1
);
    import color_pkg::*;

    logic [1:0] state;
    logic [1:0] state_nxt;
    pal_sel_t   pend_sel_0;
    pal_sel_t   pend_sel_1;
    logic       access;
    logic       addr_ok;
    logic       wr_pending;

    // --------------------
    // APB decode, no wait states
    assign access     = psel && penable;
    assign addr_ok    = (paddr == addr_pending) || (paddr == addr_active)
                     || (paddr == addr_status);
    assign wr_pending = access && pwrite && (paddr == addr_pending);
    assign pready     = access;
    assign pslverr    = access && (!addr_ok || (pwrite && (paddr != addr_pending)));

    always_comb begin
        prdata = '0;
        case (paddr)
            addr_pending: prdata[3:0] = {pend_sel_1, pend_sel_0};
            addr_active:  prdata[3:0] = {active_sel_1, active_sel_0};
            addr_status:  prdata[0]   = (state != cfg_idle);
            default:      prdata      = '0;
        endcase
    end

    // --------------------
    // Commit FSM
    always_comb begin
        state_nxt = state;
        case (state)
            cfg_idle: begin
                if (wr_pending) state_nxt = cfg_pending;
            end
            cfg_pending: begin
                if (vblank_start) state_nxt = cfg_commit;
            end
            // A write landing now waits for the next frame
            cfg_commit: state_nxt = wr_pending ? cfg_pending : cfg_idle;
            default:    state_nxt = cfg_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= cfg_idle;
            pend_sel_0   <= '0;
            pend_sel_1   <= '0;
            active_sel_0 <= '0;
            active_sel_1 <= '0;
        end else begin
            state <= state_nxt;
            if (wr_pending) begin
                pend_sel_0 <= pwdata[1:0];
                pend_sel_1 <= pwdata[3:2];
            end
            if (state == cfg_commit) begin
                active_sel_0 <= pend_sel_0;
                active_sel_1 <= pend_sel_1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/layer_mixer.sv
`default_nettype none

module layer_mixer (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire                                           blank,
    input  wire                                           hsync_raw,
    input  wire                                           vsync_raw,
    input  wire color_pkg::pix_idx_t                      bg_idx,
    input  wire [color_pkg::n_ship-1:0]                   ship_hit,
    input  wire color_pkg::rgb_t [color_pkg::n_ship-1:0]  ship_color,
    input  wire [color_pkg::n_ship-1:0]                   ship_transparent,
    input  wire [color_pkg::n_weapon-1:0]                 weapon_hit,
    input  wire color_pkg::pix_idx_t [color_pkg::n_weapon-1:0] weapon_idx,
    output logic [7:0]                                    vga_r,
    output logic [7:0]                                    vga_g,
    output logic [7:0]                                    vga_b,
    output logic                                          hsync,
    output logic                                          vsync
);
    import color_pkg::*;

    rgb_t bg_color;
    rgb_t weapon_color [n_weapon];
    rgb_t pix_color;
    rgb_t out_color;
    rgb_t color_q;

    assign bg_color = bg_palette[bg_idx];

    always_comb begin
        for (int i = 0; i < n_weapon; i++) begin
            weapon_color[i] = weapon_palette[weapon_idx[i]];
        end
    end

    // --------------------
    // Layer priority
    // Loops run high to low so the lowest index is written last and wins
    always_comb begin
        pix_color = bg_color;
        for (int s = n_ship - 1; s >= 0; s--) begin
            if (ship_hit[s] && !ship_transparent[s]) pix_color = ship_color[s];
        end
        for (int w = n_weapon - 1; w >= 0; w--) begin
            if (weapon_hit[w] && (weapon_color[w] != weapon_key)) begin
                pix_color = weapon_color[w];
            end
        end
    end

    assign out_color = blank ? '0 : pix_color;

    // --------------------
    // Output stage, sync delayed with the colour
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            color_q <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
        end else begin
            color_q <= out_color;
            hsync   <= hsync_raw;
            vsync   <= vsync_raw;
        end
    end

    assign vga_r = color_q[23:16];
    assign vga_g = color_q[15:8];
    assign vga_b = color_q[7:0];

endmodule

`default_nettype wire

// File: src/raster_counter.sv
`default_nettype none

module raster_counter (
    input  wire               clk,
    input  wire               rst_n,
    output color_pkg::coord_t draw_x,
    output color_pkg::coord_t draw_y,
    output logic              blank,
    output logic              hsync_raw,
    output logic              vsync_raw,
    output logic              vblank_start
);
    import color_pkg::*;

    logic line_end;
    logic frame_end;
    logic in_hsync;
    logic in_vsync;

    assign line_end  = (draw_x == coord_t'(h_total - 1));
    assign frame_end = (draw_y == coord_t'(v_total - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            draw_x <= '0;
            draw_y <= '0;
        end else if (line_end) begin
            draw_x <= '0;
            if (frame_end) begin
                draw_y <= '0;
            end else begin
                draw_y <= draw_y + 1'b1;
            end
        end else begin
            draw_x <= draw_x + 1'b1;
        end
    end

    // Sync pulses sit after the front porch
    assign in_hsync = (draw_x >= coord_t'(h_visible + h_front))
                   && (draw_x <  coord_t'(h_visible + h_front + h_sync));
    assign in_vsync = (draw_y >= coord_t'(v_visible + v_front))
                   && (draw_y <  coord_t'(v_visible + v_front + v_sync));

    assign hsync_raw = !in_hsync;
    assign vsync_raw = !in_vsync;
    assign blank     = (draw_x >= coord_t'(h_visible)) || (draw_y >= coord_t'(v_visible));

    // First pixel of the first blank line
    assign vblank_start = (draw_y == coord_t'(v_visible)) && (draw_x == '0);

endmodule

`default_nettype wire

// File: src/ship_palette.sv
`default_nettype none

module ship_palette (
    input  wire color_pkg::pal_sel_t sel,
    input  wire color_pkg::pix_idx_t idx,
    output color_pkg::rgb_t          color,
    output logic                     transparent
);
    import color_pkg::*;

    always_comb begin
        case (sel)
            2'd1:    color = ship_palette_1[idx];
            2'd2:    color = ship_palette_2[idx];
            // Select 3 falls back to the first table
            default: color = ship_palette_0[idx];
        endcase
    end

    assign transparent = (color == ship_key);

endmodule

`default_nettype wire

// File: vlog.f
src/color_pkg.sv
src/raster_counter.sv
src/frame_config.sv
src/ship_palette.sv
src/layer_mixer.sv
src/color_mapper_top.sv
sim/tb_clock.sv
sim/color_mapper_tb.sv
